// File: hdl/kiwi_cfg.svh
// Constants for one fixed board with a 24 MHz clk and a 256x224 visible screen

`ifndef KIWI_CFG_SVH
`define KIWI_CFG_SVH

// cen6 = clk * CEN_N / CEN_M
`define CEN_N       1
`define CEN_M       4

// Video timing in pixels and lines
`define H_TOTAL     384
`define H_ACTIVE    256
`define HS_START    296
`define HS_END      327
`define V_TOTAL     264
`define V_ACTIVE    224
`define VS_START    240
`define VS_END      243

// Address widths
`define MAIN_AW     13
`define SHR_AW      11
`define VRAM_AW     11
`define PAL_AW      8

// Main CPU memory map
`define VRAM_BASE   13'h0000
`define PAL_BASE    13'h0800
`define SHR_BASE    13'h1000
`define VCTRL_ADDR  13'h1800

`endif

// File: hdl/kiwi_pkg.sv
// Shared types for the board core and the bus_req_t address width follows MAIN_AW

`include "kiwi_cfg.svh"

package kiwi_pkg;

// CPU access passed from the main bus to the memory blocks
typedef struct packed {
    logic [`MAIN_AW-1:0] addr;
    logic [7:0]          wdata;
    logic                we;
} bus_req_t;

// Raster position and blanking/sync flags
typedef struct packed {
    logic [8:0] hdump;
    logic [8:0] vdump;
    logic       lhbl;
    logic       lvbl;
    logic       hs;
    logic       vs;
} vid_timing_t;

// Main CPU address decode result
typedef enum logic [2:0] {
    REG_VRAM,
    REG_PAL,
    REG_SHR,
    REG_VCTRL,
    REG_NONE
} region_e;

// Shared RAM owner for the current access
typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_MAIN,
    ARB_SUB
} arb_state_e;

endpackage

// File: hdl/kiwi_frac_cen.sv
// Enables are one clk wide and registered so all of them stay low during and right after reset

`timescale 1ns/1ps
`include "kiwi_cfg.svh"

module kiwi_frac_cen (
    input  logic clk,
    input  logic rst,
    output logic cen12,
    output logic cen6,
    output logic cen3,
    output logic cen1p5
);

// Steps of twice the cen6 ratio so cen12 comes out of the same sum
localparam logic [3:0] STEP  = 4'(2 * `CEN_N);
localparam logic [3:0] LIMIT = 4'(`CEN_M);

logic [3:0] acc;
logic [3:0] sum;
// Counts cen12 pulses to pick out the slower enables
logic [2:0] cnt;

assign sum = acc + STEP;

always_ff @(posedge clk) begin
    if (rst) begin
        acc    <= 4'd0;
        cnt    <= 3'd0;
        cen12  <= 1'b0;
        cen6   <= 1'b0;
        cen3   <= 1'b0;
        cen1p5 <= 1'b0;
    end else begin
        cen12  <= 1'b0;
        cen6   <= 1'b0;
        cen3   <= 1'b0;
        cen1p5 <= 1'b0;
        if (sum >= LIMIT) begin
            acc    <= sum - LIMIT;
            cnt    <= cnt + 3'd1;
            cen12  <= 1'b1;
            // Slower enables only on pulses shared with the faster ones
            cen6   <= ~cnt[0];
            cen3   <= cnt[1:0] == 2'd0;
            cen1p5 <= cnt == 3'd0;
        end else begin
            acc <= sum;
        end
    end
end

endmodule

// File: hdl/kiwi_main_bus.sv
// Main CPU Wishbone slave that serves one access at a time and holds cyc/stb until ack

`timescale 1ns/1ps
`include "kiwi_cfg.svh"

module kiwi_main_bus import kiwi_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                main_wb_cyc,
    input  logic                main_wb_stb,
    input  logic                main_wb_we,
    input  logic [`MAIN_AW-1:0] main_wb_adr,
    input  logic [7:0]          main_wb_dat_w,
    output logic [7:0]          main_wb_dat_r,
    output logic                main_wb_ack,
    output bus_req_t            shr_req,
    output logic                shr_valid,
    input  logic                shr_ack,
    input  logic [7:0]          shr_rdata,
    output bus_req_t            vid_req,
    output logic                vram_sel,
    output logic                pal_sel,
    input  logic [7:0]          vid_rdata,
    output logic                flip,
    output logic                vid_en
);

typedef enum logic {BUS_IDLE, BUS_BUSY} bus_state_e;

bus_state_e st;
bus_req_t   req;
region_e    region;
logic [7:0] vctrl;
logic       fix_ack;
logic       shr_done;
logic       start;

function automatic logic in_win(input logic [`MAIN_AW-1:0] a,
                                input logic [`MAIN_AW-1:0] base, input int aw);
    logic [`MAIN_AW-1:0] ofs;
    ofs = a - base;
    return int'(ofs) < (1 << aw);
endfunction

function automatic region_e decode(input logic [`MAIN_AW-1:0] a);
    if (in_win(a, `VRAM_BASE, `VRAM_AW))
        return REG_VRAM;
    else if (in_win(a, `PAL_BASE, `PAL_AW))
        return REG_PAL;
    else if (in_win(a, `SHR_BASE, `SHR_AW))
        return REG_SHR;
    else if (a == `VCTRL_ADDR)
        return REG_VCTRL;
    else
        return REG_NONE;
endfunction

// No new request while the previous ack is still on the bus
assign start    = main_wb_cyc & main_wb_stb & ~main_wb_ack & (st == BUS_IDLE);
assign shr_done = (st == BUS_BUSY) & (region == REG_SHR) & shr_ack;

assign main_wb_ack = fix_ack | shr_done;
assign shr_req     = req;
assign vid_req     = req;
assign shr_valid   = (st == BUS_BUSY) & (region == REG_SHR);
assign vram_sel    = (st == BUS_BUSY) & (region == REG_VRAM);
assign pal_sel     = (st == BUS_BUSY) & (region == REG_PAL);
assign flip        = vctrl[0];
assign vid_en      = vctrl[1];

always_ff @(posedge clk) begin
    if (start)
        req <= '{addr: main_wb_adr, wdata: main_wb_dat_w, we: main_wb_we};
end

always_ff @(posedge clk) begin
    if (rst) begin
        st      <= BUS_IDLE;
        region  <= REG_NONE;
        fix_ack <= 1'b0;
        vctrl   <= 8'd0;
    end else begin
        fix_ack <= 1'b0;
        case (st)
            BUS_IDLE: begin
                if (start) begin
                    st     <= BUS_BUSY;
                    region <= decode(main_wb_adr);
                end
            end
            default: begin
                if (region != REG_SHR) begin
                    // Fixed path, video data is ready by now
                    fix_ack <= 1'b1;
                    st      <= BUS_IDLE;
                    if (region == REG_VCTRL && req.we)
                        vctrl <= req.wdata;
                end else if (shr_ack) begin
                    st <= BUS_IDLE;
                end
            end
        endcase
    end
end

always_comb begin
    case (region)
        REG_VRAM, REG_PAL: main_wb_dat_r = vid_rdata;
        REG_SHR:           main_wb_dat_r = shr_rdata;
        REG_VCTRL:         main_wb_dat_r = vctrl;
        default:           main_wb_dat_r = 8'hFF;
    endcase
end

endmodule

// File: hdl/kiwi_shared_ram.sv
// Shared RAM where main_valid must drop in the cycle after main_ack and main wins ties

`timescale 1ns/1ps
`include "kiwi_cfg.svh"

module kiwi_shared_ram import kiwi_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  bus_req_t           main_req,
    input  logic               main_valid,
    output logic               main_ack,
    output logic [7:0]         main_rdata,
    input  logic               sub_wb_cyc,
    input  logic               sub_wb_stb,
    input  logic               sub_wb_we,
    input  logic [`SHR_AW-1:0] sub_wb_adr,
    input  logic [7:0]         sub_wb_dat_w,
    output logic [7:0]         sub_wb_dat_r,
    output logic               sub_wb_ack
);

logic [7:0] mem [0:2**`SHR_AW-1];

arb_state_e         st;
logic               sub_pend;
logic               grant_main;
logic               grant_sub;
logic [`SHR_AW-1:0] addr;
logic [7:0]         wdata;
logic               we;
logic [7:0]         rdata;

// Sub request registered once so both ports reach the arbiter with equal delay
always_ff @(posedge clk) begin
    if (rst)
        sub_pend <= 1'b0;
    else if (grant_sub)
        sub_pend <= 1'b0;
    else if (sub_wb_cyc && sub_wb_stb && !sub_wb_ack)
        sub_pend <= 1'b1;
end

always_comb begin
    // main_valid is stale while its own ack is out
    grant_main = main_valid && (st != ARB_MAIN);
    grant_sub  = sub_pend && !grant_main;
end

assign addr  = grant_main ? main_req.addr[`SHR_AW-1:0] : sub_wb_adr;
assign wdata = grant_main ? main_req.wdata : sub_wb_dat_w;
assign we    = grant_main ? main_req.we : sub_wb_we;

always_ff @(posedge clk) begin
    if (grant_main || grant_sub) begin
        if (we)
            mem[addr] <= wdata;
        rdata <= mem[addr];
    end
end

always_ff @(posedge clk) begin
    if (rst) begin
        st         <= ARB_IDLE;
        main_ack   <= 1'b0;
        sub_wb_ack <= 1'b0;
    end else begin
        main_ack   <= grant_main;
        sub_wb_ack <= grant_sub;
        if (grant_main)
            st <= ARB_MAIN;
        else if (grant_sub)
            st <= ARB_SUB;
        else
            st <= ARB_IDLE;
    end
end

assign main_rdata   = rdata;
assign sub_wb_dat_r = rdata;

endmodule

// File: hdl/kiwi_video.sv
// One palette index per 8x8 block with RGB 3-3-2 out two pxl_cen ticks behind hdump

`timescale 1ns/1ps
`include "kiwi_cfg.svh"

module kiwi_video import kiwi_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        pxl_cen,
    input  bus_req_t    cpu_req,
    input  logic        vram_sel,
    input  logic        pal_sel,
    input  logic        flip,
    input  logic        vid_en,
    output logic [7:0]  cpu_rdata,
    output vid_timing_t timing,
    output logic [2:0]  red,
    output logic [2:0]  green,
    output logic [1:0]  blue
);

localparam logic [5:0] LAST_ROW = 6'(`V_ACTIVE / 8 - 1);
localparam logic [4:0] LAST_COL = 5'(`H_ACTIVE / 8 - 1);

logic [7:0] vram [0:2**`VRAM_AW-1];
logic [7:0] pal  [0:2**`PAL_AW-1];

logic [8:0]          hcnt;
logic [8:0]          vcnt;
logic                lhbl;
logic                lvbl;
logic                hs;
logic                vs;
logic [5:0]          row;
logic [4:0]          col;
logic [`VRAM_AW-1:0] scan_addr;
logic [7:0]          pal_idx;
logic                lhbl_d;
logic                lvbl_d;
logic [7:0]          pxl;

// Raster counters
always_ff @(posedge clk) begin
    if (rst) begin
        hcnt <= 9'd0;
        vcnt <= 9'd0;
    end else if (pxl_cen) begin
        if (hcnt == 9'(`H_TOTAL - 1)) begin
            hcnt <= 9'd0;
            vcnt <= (vcnt == 9'(`V_TOTAL - 1)) ? 9'd0 : vcnt + 9'd1;
        end else begin
            hcnt <= hcnt + 9'd1;
        end
    end
end

assign lhbl = hcnt < 9'(`H_ACTIVE);
assign lvbl = vcnt < 9'(`V_ACTIVE);
assign hs   = (hcnt >= 9'(`HS_START)) && (hcnt <= 9'(`HS_END));
assign vs   = (vcnt >= 9'(`VS_START)) && (vcnt <= 9'(`VS_END));

assign timing = '{hdump: hcnt, vdump: vcnt, lhbl: lhbl, lvbl: lvbl, hs: hs, vs: vs};

// CPU port of both memories
always_ff @(posedge clk) begin
    if (vram_sel && cpu_req.we)
        vram[cpu_req.addr[`VRAM_AW-1:0]] <= cpu_req.wdata;
    if (pal_sel && cpu_req.we)
        pal[cpu_req.addr[`PAL_AW-1:0]] <= cpu_req.wdata;
    if (vram_sel)
        cpu_rdata <= vram[cpu_req.addr[`VRAM_AW-1:0]];
    else if (pal_sel)
        cpu_rdata <= pal[cpu_req.addr[`PAL_AW-1:0]];
end

// Block row and column of the current pixel
assign row = vcnt[8:3];
assign col = hcnt[7:3];
// Mirror both axes when flipped
assign scan_addr = flip ? {LAST_ROW - row, LAST_COL - col} : {row, col};

// Stage 1 fetches the palette index
always_ff @(posedge clk) begin
    if (pxl_cen)
        pal_idx <= vram[scan_addr];
end

// Stage 2 looks up the colour and blanks with flags delayed to match
always_ff @(posedge clk) begin
    if (rst) begin
        lhbl_d <= 1'b1;
        lvbl_d <= 1'b1;
        pxl    <= 8'd0;
    end else if (pxl_cen) begin
        lhbl_d <= lhbl;
        lvbl_d <= lvbl;
        pxl    <= (lhbl_d && lvbl_d && vid_en) ? pal[pal_idx] : 8'd0;
    end
end

assign {red, green, blue} = pxl;

endmodule

// File: hdl/kiwi_game.sv
// Board top with one 24 MHz clk where pxl_cen is cen6 and pxl2_cen runs at twice that rate

`timescale 1ns/1ps
`include "kiwi_cfg.svh"

module kiwi_game import kiwi_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                main_wb_cyc,
    input  logic                main_wb_stb,
    input  logic                main_wb_we,
    input  logic [`MAIN_AW-1:0] main_wb_adr,
    input  logic [7:0]          main_wb_dat_w,
    output logic [7:0]          main_wb_dat_r,
    output logic                main_wb_ack,
    input  logic                sub_wb_cyc,
    input  logic                sub_wb_stb,
    input  logic                sub_wb_we,
    input  logic [`SHR_AW-1:0]  sub_wb_adr,
    input  logic [7:0]          sub_wb_dat_w,
    output logic [7:0]          sub_wb_dat_r,
    output logic                sub_wb_ack,
    output logic                pxl_cen,
    output logic                pxl2_cen,
    output logic                cen3,
    output logic                cen1p5,
    output vid_timing_t         timing,
    output logic [2:0]          red,
    output logic [2:0]          green,
    output logic [1:0]          blue,
    output logic                flip
);

bus_req_t   shr_req;
bus_req_t   vid_req;
logic       shr_valid;
logic       shr_ack;
logic [7:0] shr_rdata;
logic       vram_sel;
logic       pal_sel;
logic [7:0] vid_rdata;
logic       vid_en;

kiwi_frac_cen u_cen(
    .clk        ( clk       ),
    .rst        ( rst       ),
    .cen12      ( pxl2_cen  ),
    .cen6       ( pxl_cen   ),
    .cen3       ( cen3      ),
    .cen1p5     ( cen1p5    )
);

kiwi_main_bus u_main(
    .clk            ( clk           ),
    .rst            ( rst           ),
    .main_wb_cyc    ( main_wb_cyc   ),
    .main_wb_stb    ( main_wb_stb   ),
    .main_wb_we     ( main_wb_we    ),
    .main_wb_adr    ( main_wb_adr   ),
    .main_wb_dat_w  ( main_wb_dat_w ),
    .main_wb_dat_r  ( main_wb_dat_r ),
    .main_wb_ack    ( main_wb_ack   ),
    // Shared RAM
    .shr_req        ( shr_req       ),
    .shr_valid      ( shr_valid     ),
    .shr_ack        ( shr_ack       ),
    .shr_rdata      ( shr_rdata     ),
    // Video
    .vid_req        ( vid_req       ),
    .vram_sel       ( vram_sel      ),
    .pal_sel        ( pal_sel       ),
    .vid_rdata      ( vid_rdata     ),
    .flip           ( flip          ),
    .vid_en         ( vid_en        )
);

kiwi_shared_ram u_shr(
    .clk            ( clk           ),
    .rst            ( rst           ),
    .main_req       ( shr_req       ),
    .main_valid     ( shr_valid     ),
    .main_ack       ( shr_ack       ),
    .main_rdata     ( shr_rdata     ),
    // Sub CPU port
    .sub_wb_cyc     ( sub_wb_cyc    ),
    .sub_wb_stb     ( sub_wb_stb    ),
    .sub_wb_we      ( sub_wb_we     ),
    .sub_wb_adr     ( sub_wb_adr    ),
    .sub_wb_dat_w   ( sub_wb_dat_w  ),
    .sub_wb_dat_r   ( sub_wb_dat_r  ),
    .sub_wb_ack     ( sub_wb_ack    )
);

kiwi_video u_video(
    .clk            ( clk           ),
    .rst            ( rst           ),
    .pxl_cen        ( pxl_cen       ),
    .cpu_req        ( vid_req       ),
    .vram_sel       ( vram_sel      ),
    .pal_sel        ( pal_sel       ),
    .flip           ( flip          ),
    .vid_en         ( vid_en        ),
    .cpu_rdata      ( vid_rdata     ),
    .timing         ( timing        ),
    // pixels
    .red            ( red           ),
    .green          ( green         ),
    .blue           ( blue          )
);

endmodule

// File: test/kiwi_game_mon.sv
// Samples DUT ports on rising clk and compares them with expectations armed before each access

`timescale 1ns/1ps
`include "kiwi_cfg.svh"

module kiwi_game_mon import kiwi_pkg::*; (
    input logic                clk,
    input logic                rst,
    input logic                main_wb_cyc,
    input logic                main_wb_stb,
    input logic [`MAIN_AW-1:0] main_wb_adr,
    input logic                main_wb_ack,
    input logic [7:0]          main_wb_dat_r,
    input logic                sub_wb_ack,
    input logic [7:0]          sub_wb_dat_r,
    input logic                pxl_cen,
    input logic                pxl2_cen,
    input logic                cen3,
    input logic                cen1p5,
    input vid_timing_t         timing,
    input logic [2:0]          red,
    input logic [2:0]          green,
    input logic [1:0]          blue,
    input logic                flip
);

int unsigned   cyc = 0;
int            err_total = 0;
int            test_err = 0;
int            tests_run = 0;
reg [8*24-1:0] test_name = "none";
// Main port tracking
logic          main_busy = 0;
logic          main_fixed = 0;
int unsigned   main_t0 = 0;
int unsigned   main_ack_cyc = 0;
int unsigned   sub_ack_cyc = 0;
logic          main_chk = 0;
logic [7:0]    main_exp;
logic          sub_chk = 0;
logic [7:0]    sub_exp;
// Pixel probe
logic          pix_armed = 0;
int            pix_stage = 0;
logic [8:0]    pix_h;
logic [8:0]    pix_v;
logic [7:0]    pix_exp;
// Enable counting window and raster counts
int            cen_left = 0;
int            n12;
int            n6;
int            n3;
int            n1p5;
int            hi_cnt;
int            lo_cnt;
int            hs_cnt;
int            vb_lines;
int            vs_lines;
int            frames_done = 0;

task automatic value_error(input string name, input [31:0] got, input [31:0] exp);
    $display("FAILED %0s got 0x%0h expected 0x%0h", name, got, exp);
    err_total++;
    test_err++;
endtask

task automatic plain_error(input string msg);
    $display("Error in %0s: %0s", test_name, msg);
    err_total++;
    test_err++;
endtask

task automatic start_test(input [8*24-1:0] name);
    test_name = name;
    test_err  = 0;
    tests_run++;
endtask

task automatic finish_test();
    $display("%0s finished with %0d errors", test_name, test_err);
endtask

task automatic print_summary(input int extra);
    $display("%0d tests run, %0d monitor errors, %0d assertion errors",
             tests_run, err_total, extra);
endtask

task automatic arm_main(input [7:0] exp);
    main_exp = exp;
    main_chk = 1;
endtask

task automatic arm_sub(input [7:0] exp);
    sub_exp = exp;
    sub_chk = 1;
endtask

task automatic expect_pixel(input [8:0] h, input [8:0] v, input [7:0] exp);
    pix_h     = h;
    pix_v     = v;
    pix_exp   = exp;
    pix_stage = 0;
    pix_armed = 1;
endtask

task automatic count_cens();
    n12      = 0;
    n6       = 0;
    n3       = 0;
    n1p5     = 0;
    cen_left = 64;
endtask

task automatic check_main_first();
    if (main_ack_cyc >= sub_ack_cyc)
        plain_error("sub ack came before main ack on a tie");
endtask

// Flip follows bit 0 of the last VCTRL write
task automatic check_flip(input logic exp);
    if (flip !== exp)
        value_error("flip", flip, exp);
endtask

always @(posedge clk) begin
    cyc++;
    if (rst) begin
        main_busy = 0;
        hi_cnt    = 0;
        lo_cnt    = 0;
        hs_cnt    = 0;
        vb_lines  = 0;
        vs_lines  = 0;
    end else begin
        if (main_wb_ack) begin
            main_ack_cyc = cyc;
            main_busy    = 0;
            if (main_fixed && (cyc - main_t0) != 2)
                plain_error($sformatf("main ack after %0d cycles", cyc - main_t0));
            if (main_chk && main_wb_dat_r !== main_exp)
                value_error("main_wb_dat_r", main_wb_dat_r, main_exp);
            main_chk = 0;
        end else if (main_wb_cyc && main_wb_stb && !main_busy) begin
            main_busy  = 1;
            main_t0    = cyc;
            // Shared RAM window has a variable latency
            main_fixed = main_wb_adr[12:11] != 2'b10;
        end
        if (sub_wb_ack) begin
            sub_ack_cyc = cyc;
            if (sub_chk && sub_wb_dat_r !== sub_exp)
                value_error("sub_wb_dat_r", sub_wb_dat_r, sub_exp);
            sub_chk = 0;
        end
        if (cen_left > 0) begin
            n12  += pxl2_cen;
            n6   += pxl_cen;
            n3   += cen3;
            n1p5 += cen1p5;
            if ((cen3 || cen1p5) && !pxl_cen)
                plain_error("cen3 or cen1p5 without cen6");
            if (pxl_cen && !pxl2_cen)
                plain_error("cen6 without pxl2_cen");
            cen_left--;
            if (cen_left == 0) begin
                if (n12 != 32)
                    value_error("pxl2_cen pulses", n12, 32);
                if (n6 != 16)
                    value_error("cen6 pulses", n6, 16);
                if (n3 != 8)
                    value_error("cen3 pulses", n3, 8);
                if (n1p5 != 4)
                    value_error("cen1p5 pulses", n1p5, 4);
            end
        end
        // Colour is out after the second tick following hdump == h
        if (pix_armed) begin
            if (pix_stage == 2) begin
                if ({red, green, blue} !== pix_exp)
                    value_error("rgb", {red, green, blue}, pix_exp);
                pix_armed = 0;
            end else if (pxl_cen) begin
                if (pix_stage == 1)
                    pix_stage = 2;
                else if (timing.hdump == pix_h && timing.vdump == pix_v)
                    pix_stage = 1;
            end
        end
        if (pxl_cen) begin
            if (timing.lhbl)
                hi_cnt++;
            else
                lo_cnt++;
            if (timing.hs)
                hs_cnt++;
            if (timing.hdump == 9'(`H_TOTAL - 1)) begin
                if (hi_cnt != 256)
                    value_error("lhbl high count", hi_cnt, 256);
                if (lo_cnt != 128)
                    value_error("lhbl low count", lo_cnt, 128);
                if (hs_cnt != 32)
                    value_error("hs count", hs_cnt, 32);
                hi_cnt = 0;
                lo_cnt = 0;
                hs_cnt = 0;
                if (!timing.lvbl)
                    vb_lines++;
                if (timing.vs)
                    vs_lines++;
                if (timing.vdump == 9'(`V_TOTAL - 1)) begin
                    if (vb_lines != 40)
                        value_error("lvbl low lines", vb_lines, 40);
                    if (vs_lines != 4)
                        value_error("vs lines", vs_lines, 4);
                    vb_lines = 0;
                    vs_lines = 0;
                    frames_done++;
                end
            end
        end
    end
end

endmodule

// File: test/kiwi_game_chk.sv
// Bus, clock enable and blanking rules for kiwi_game with every failure counted in fails

`timescale 1ns/1ps

module kiwi_game_chk import kiwi_pkg::*; (
    input logic        clk,
    input logic        rst,
    input logic        main_wb_stb,
    input logic        main_wb_ack,
    input logic        sub_wb_stb,
    input logic        sub_wb_ack,
    input logic        pxl_cen,
    input logic        cen3,
    input logic        cen1p5,
    input vid_timing_t timing,
    input logic [2:0]  red,
    input logic [2:0]  green,
    input logic [1:0]  blue
);

int   fails = 0;
logic lhbl_q1;
logic lhbl_q2;
logic lvbl_q1;
logic lvbl_q2;

// Blanking flags delayed like the pixel pipeline
always_ff @(posedge clk) begin
    if (rst) begin
        lhbl_q1 <= 1'b1;
        lhbl_q2 <= 1'b1;
        lvbl_q1 <= 1'b1;
        lvbl_q2 <= 1'b1;
    end else if (pxl_cen) begin
        lhbl_q1 <= timing.lhbl;
        lhbl_q2 <= lhbl_q1;
        lvbl_q1 <= timing.lvbl;
        lvbl_q2 <= lvbl_q1;
    end
end

main_ack_pulse: assert property (@(posedge clk) disable iff (rst)
    main_wb_ack |-> main_wb_stb ##1 !main_wb_ack)
    else begin
        fails++;
        $error("main ack is not a single pulse under stb");
    end

sub_ack_pulse: assert property (@(posedge clk) disable iff (rst)
    sub_wb_ack |-> sub_wb_stb ##1 !sub_wb_ack)
    else begin
        fails++;
        $error("sub ack is not a single pulse under stb");
    end

blank_black: assert property (@(posedge clk) disable iff (rst)
    !(lhbl_q2 && lvbl_q2) |-> ({red, green, blue} == 8'd0))
    else begin
        fails++;
        $error("rgb not black during blanking");
    end

cen_nested: assert property (@(posedge clk) disable iff (rst)
    (cen3 |-> pxl_cen) and (cen1p5 |-> cen3))
    else begin
        fails++;
        $error("slow clock enable without cen6");
    end

endmodule

bind kiwi_game kiwi_game_chk u_chk(
    .clk         ( clk         ),
    .rst         ( rst         ),
    .main_wb_stb ( main_wb_stb ),
    .main_wb_ack ( main_wb_ack ),
    .sub_wb_stb  ( sub_wb_stb  ),
    .sub_wb_ack  ( sub_wb_ack  ),
    .pxl_cen     ( pxl_cen     ),
    .cen3        ( cen3        ),
    .cen1p5      ( cen1p5      ),
    .timing      ( timing      ),
    .red         ( red         ),
    .green       ( green       ),
    .blue        ( blue        )
);

// File: test/kiwi_game_tb.sv
// Runs the golden operations and needs the project root as working directory

`timescale 1ns/1ps
`include "kiwi_cfg.svh"

module kiwi_game_tb;
import kiwi_pkg::*;

logic                clk = 0;
logic                rst = 1;
logic                main_wb_cyc = 0;
logic                main_wb_stb = 0;
logic                main_wb_we = 0;
logic [`MAIN_AW-1:0] main_wb_adr = '0;
logic [7:0]          main_wb_dat_w = '0;
logic [7:0]          main_wb_dat_r;
logic                main_wb_ack;
logic                sub_wb_cyc = 0;
logic                sub_wb_stb = 0;
logic                sub_wb_we = 0;
logic [`SHR_AW-1:0]  sub_wb_adr = '0;
logic [7:0]          sub_wb_dat_w = '0;
logic [7:0]          sub_wb_dat_r;
logic                sub_wb_ack;
logic                pxl_cen;
logic                pxl2_cen;
logic                cen3;
logic                cen1p5;
logic                flip;
vid_timing_t         timing;
logic [2:0]          red;
logic [2:0]          green;
logic [1:0]          blue;
logic [15:0]         lfsr = 16'd50740;

always #4 clk = ~clk;

kiwi_game i_dut(.*);

kiwi_game_mon i_mon(.*);

task automatic give_up(input string msg);
    i_mon.plain_error(msg);
    $display("Test failed");
    $finish;
endtask

// Taps 16, 14, 13, 11
function automatic [15:0] lfsr_next(input [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

task automatic rand_byte(output [7:0] r);
    for (int i = 0; i < 8; i++) begin
        lfsr = lfsr_next(lfsr);
        r    = {r[6:0], lfsr[0]};
    end
endtask

task automatic main_access(input logic we, input [15:0] adr, input [7:0] dat);
    int n;
    main_wb_cyc   = 1;
    main_wb_stb   = 1;
    main_wb_we    = we;
    main_wb_adr   = adr[`MAIN_AW-1:0];
    main_wb_dat_w = dat;
    n = 0;
    do begin
        @(negedge clk);
        n++;
    end while (!main_wb_ack && n < 50);
    if (!main_wb_ack)
        give_up("main port never acked");
    @(negedge clk);
    main_wb_cyc = 0;
    main_wb_stb = 0;
endtask

task automatic sub_access(input logic we, input [15:0] adr, input [7:0] dat);
    int n;
    sub_wb_cyc   = 1;
    sub_wb_stb   = 1;
    sub_wb_we    = we;
    sub_wb_adr   = adr[`SHR_AW-1:0];
    sub_wb_dat_w = dat;
    n = 0;
    do begin
        @(negedge clk);
        n++;
    end while (!sub_wb_ack && n < 50);
    if (!sub_wb_ack)
        give_up("sub port never acked");
    @(negedge clk);
    sub_wb_cyc = 0;
    sub_wb_stb = 0;
endtask

initial begin
    int            fd;
    int            n;
    int            frames;
    int            waited;
    string         line;
    reg [8*24-1:0] op;
    reg [8*24-1:0] tname;
    reg [15:0]     a;
    reg [15:0]     b;
    reg [15:0]     c;
    reg [15:0]     d;
    reg [7:0]      r;
    fd = $fopen("test/kiwi_game_golden.txt", "r");
    if (fd == 0)
        give_up("cannot open test/kiwi_game_golden.txt");
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 0;
    while (!$feof(fd)) begin
        line = "";
        a    = 0;
        b    = 0;
        c    = 0;
        d    = 0;
        op   = 0;
        n = $fgets(line, fd);
        n = $sscanf(line, "%s %h %h %h %h", op, a, b, c, d);
        if (n < 1 || op == "#")
            continue;
        if (op == "T") begin
            n = $sscanf(line, "%s %s", op, tname);
            if (i_mon.tests_run > 0)
                i_mon.finish_test();
            i_mon.start_test(tname);
        end else if (op == "MW") begin
            main_access(1, a, b[7:0]);
        end else if (op == "MR") begin
            i_mon.arm_main(b[7:0]);
            main_access(0, a, 0);
        end else if (op == "SW") begin
            sub_access(1, a, b[7:0]);
        end else if (op == "SR") begin
            i_mon.arm_sub(b[7:0]);
            sub_access(0, a, 0);
        end else if (op == "SX") begin
            rand_byte(r);
            sub_access(1, a, r);
            i_mon.arm_main(r);
            main_access(0, `SHR_BASE | a, 0);
        end else if (op == "SIM") begin
            i_mon.arm_main(b[7:0]);
            i_mon.arm_sub(d[7:0]);
            fork
                main_access(0, a, 0);
                sub_access(0, c, 0);
            join
            i_mon.check_main_first();
        end else if (op == "VC") begin
            main_access(1, `VCTRL_ADDR, a[7:0]);
            i_mon.check_flip(a[0]);
        end else if (op == "PX") begin
            i_mon.expect_pixel(a[8:0], b[8:0], c[7:0]);
            waited = 0;
            while (i_mon.pix_armed && waited < 600000) begin
                @(negedge clk);
                waited++;
            end
            if (i_mon.pix_armed)
                give_up("pixel position never reached");
        end else if (op == "CEN") begin
            i_mon.count_cens();
            waited = 0;
            while (i_mon.cen_left > 0 && waited < 200) begin
                @(negedge clk);
                waited++;
            end
            if (i_mon.cen_left > 0)
                give_up("clock enable window did not close");
        end else if (op == "TIM") begin
            frames = i_mon.frames_done;
            waited = 0;
            while (i_mon.frames_done == frames && waited < 900000) begin
                @(negedge clk);
                waited++;
            end
            if (i_mon.frames_done == frames)
                give_up("no full video frame seen");
        end else begin
            i_mon.plain_error("unknown operation in golden file");
        end
    end
    $fclose(fd);
    i_mon.finish_test();
    i_mon.print_summary(i_dut.u_chk.fails);
    if (i_mon.err_total == 0 && i_dut.u_chk.fails == 0)
        $display("Test passed");
    else
        $display("Test failed");
    $finish;
end

endmodule

// File: kiwi_game.f
+incdir+hdl
hdl/kiwi_pkg.sv
hdl/kiwi_frac_cen.sv
hdl/kiwi_main_bus.sv
hdl/kiwi_shared_ram.sv
hdl/kiwi_video.sv
hdl/kiwi_game.sv
test/kiwi_game_mon.sv
test/kiwi_game_chk.sv
test/kiwi_game_tb.sv

// File: test/kiwi_game_golden.txt
# op a b c d, all fields hex, unused fields 0
# T name | MW/MR addr data | SW/SR addr data | SX addr | SIM maddr mexp saddr sexp
# VC value | PX h v rgb | CEN | TIM
T memory_map
MW 0010 3C 0 0
MR 0010 3C 0 0
MW 08FF 81 0 0
MR 08FF 81 0 0
MW 1800 00 0 0
MR 1800 00 0 0
MW 0900 12 0 0
MR 0900 FF 0 0
MR 1801 FF 0 0
T shared_ram
MW 1005 A7 0 0
SR 005 A7 0 0
SW 123 4E 0 0
MR 1123 4E 0 0
SX 200 0 0 0
SX 201 0 0 0
SIM 1005 A7 123 4E
T clock_enables
CEN 0 0 0 0
T video_timing
TIM 0 0 0 0
T pixel_colour
MW 0000 05 0 0
MW 0805 B6 0 0
MW 0043 07 0 0
MW 0807 2D 0 0
MW 037F 09 0 0
MW 0809 5A 0 0
VC 02 0 0 0
PX 000 000 B6 0
PX 01A 011 2D 0
PX 104 000 00 0
VC 03 0 0 0
PX 000 000 5A 0
VC 00 0 0 0
PX 000 000 00 0
